/* project.f */
+incdir+design
design/rv_isa_pkg.sv
design/lsu_bus_pkg.sv
design/mem_stage_latch.sv
design/mem_access_ctrl.sv
design/sram_axi_lite.sv
design/load_align.sv
design/mem_stage_top.sv
verification/mem_stage_assert.sv
verification/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

export_include_dirs:
  - design

sources:
  - target: any(simulation, synthesis)
    include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/lsu_bus_pkg.sv
      - design/mem_stage_latch.sv
      - design/mem_access_ctrl.sv
      - design/sram_axi_lite.sv
      - design/load_align.sv
      - design/mem_stage_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/mem_stage_assert.sv
      - verification/mem_stage_tb.sv

/* verification/mem_stage_patterns.txt */
// opcode funct3 address rs2_data result rd expected_load_data
// one instruction per line, all fields hex
23 2 00000010 87654321 00000010 01 00000000
23 2 00000014 a5c3f00e 00000014 02 00000000
03 2 00000010 00000000 00000010 03 87654321
03 2 00000014 00000000 00000014 04 a5c3f00e
03 2 00000018 00000000 00000018 05 00000000
33 0 00000000 00000000 dead0001 06 00000000
23 0 00000011 000000ab 00000011 07 00000000
03 2 00000010 00000000 00000010 08 8765ab21
23 1 00000016 1234beef 00000016 09 00000000
03 2 00000014 00000000 00000014 0a beeff00e
03 0 00000010 00000000 00000010 0b 00000021
03 0 00000011 00000000 00000011 0c ffffffab
03 0 00000012 00000000 00000012 0d 00000065
03 0 00000013 00000000 00000013 0e ffffff87
03 4 00000010 00000000 00000010 0f 00000021
03 4 00000011 00000000 00000011 10 000000ab
03 4 00000016 00000000 00000016 11 000000ef
03 4 00000013 00000000 00000013 12 00000087
03 1 00000010 00000000 00000010 13 ffffab21
03 1 00000012 00000000 00000012 14 ffff8765
03 5 00000014 00000000 00000014 15 0000f00e
03 5 00000016 00000000 00000016 16 0000beef
13 0 00000000 00000000 00000042 17 00000000

/* verification/mem_stage_tb.sv */
`timescale 1ns/1ns
`include "mem_stage_params.svh"

module mem_stage_tb
    import rv_isa_pkg::*;
();

    localparam int FIELDS  = 7;
    localparam int MAX_PAT = 64;
    localparam int TIMEOUT = 50;

    logic                      clk;
    logic                      rst;
    logic                      exu_done_i;
    logic [`MS_XLEN-1:0]       pc_i;
    logic [`MS_XLEN-1:0]       inst_i;
    logic [`MS_XLEN-1:0]       result_i;
    logic [`MS_XLEN-1:0]       addr_i;
    logic [`MS_XLEN-1:0]       rs2_data_i;
    logic [`MS_REG_ADDR_W-1:0] rd_addr_i;
    logic                      mem_done_o;
    logic [`MS_XLEN-1:0]       pc_o;
    logic [`MS_XLEN-1:0]       inst_o;
    logic [`MS_XLEN-1:0]       result_o;
    logic [`MS_REG_ADDR_W-1:0] rd_addr_o;
    logic [`MS_XLEN-1:0]       load_data_o;
    logic                      busy_o;

    // Seven words per instruction as in the pattern file columns
    logic [31:0] pat_mem [0:FIELDS*MAX_PAT-1];
    int          n_pat;
    int          checks;
    int          errors;
    int          timeouts;
    int          assert_errors;
    int          gap;
    logic        timed_out;

    mem_stage_top u_mem_stage_top (
        .clk(clk), .rst(rst), .exu_done_i(exu_done_i), .pc_i(pc_i), .inst_i(inst_i),
        .result_i(result_i), .addr_i(addr_i), .rs2_data_i(rs2_data_i),
        .rd_addr_i(rd_addr_i), .mem_done_o(mem_done_o), .pc_o(pc_o), .inst_o(inst_o),
        .result_o(result_o), .rd_addr_o(rd_addr_o), .load_data_o(load_data_o),
        .busy_o(busy_o)
    );

    bind mem_access_ctrl mem_stage_assert u_ctrl_assert (
        .clk(clk), .rst(rst), .state_i(state), .awvalid_i(awvalid_o),
        .awready_i(awready_i), .wvalid_i(wvalid_o), .arvalid_i(arvalid_o),
        .arready_i(arready_i), .bready_i(bready_o), .rready_i(rready_o), .done_i(done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH time=%0t %s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    // Hand one instruction to the stage and check what comes back at done
    task automatic run_instruction(input int idx, output logic stuck);
        logic [6:0]  opcode;
        logic [2:0]  f3;
        logic [31:0] addr;
        logic [31:0] rs2;
        logic [31:0] result;
        logic [4:0]  rd;
        logic [31:0] exp_load;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        probe;
        logic        done_seen;
        int          cycles;
        int          exp_cycles;
        opcode   = pat_mem[idx*FIELDS][6:0];
        f3       = pat_mem[idx*FIELDS+1][2:0];
        addr     = pat_mem[idx*FIELDS+2];
        rs2      = pat_mem[idx*FIELDS+3];
        result   = pat_mem[idx*FIELDS+4];
        rd       = pat_mem[idx*FIELDS+5][4:0];
        exp_load = pat_mem[idx*FIELDS+6];
        pc       = 32'h0000_1000 + 32'(idx) * 4;
        inst     = {12'(idx), 5'd0, f3, rd, opcode};
        probe    = (idx % 2 == 1);
        if (opcode == OPC_LOAD || opcode == OPC_STORE) begin
            exp_cycles = `MS_SRAM_LATENCY + 3;
        end else begin
            exp_cycles = 2;
        end

        @(posedge clk);
        pc_i       <= pc;
        inst_i     <= inst;
        result_i   <= result;
        addr_i     <= addr;
        rs2_data_i <= rs2;
        rd_addr_i  <= rd;
        exu_done_i <= 1'b1;

        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < TIMEOUT) begin
            @(posedge clk);
            if (cycles == 0) begin
                exu_done_i <= 1'b0;
            end else if (cycles == 1 && probe) begin
                // A strobe with other data while busy is to be dropped
                exu_done_i <= 1'b1;
                pc_i       <= ~pc;
                inst_i     <= ~inst;
                result_i   <= ~result;
                addr_i     <= ~addr;
                rd_addr_i  <= ~rd;
            end
            @(negedge clk);
            cycles++;
            done_seen = mem_done_o;
            // Stage stays occupied from capture through the done cycle
            check_value("busy_o", 32'd1, 32'(busy_o));
        end

        stuck = !done_seen;
        if (!done_seen) begin
            timeouts++;
            $display("no mem_done_o within timeout (instruction %0d)", idx);
        end else begin
            check_value("mem_done_o latency", 32'(exp_cycles), 32'(cycles));
            check_value("load_data_o", exp_load, load_data_o);
            check_value("pc_o", pc, pc_o);
            check_value("inst_o", inst, inst_o);
            check_value("result_o", result, result_o);
            check_value("rd_addr_o", 32'(rd), 32'(rd_addr_o));
            @(posedge clk);
            exu_done_i <= 1'b0;
            @(negedge clk);
            check_value("mem_done_o", 32'd0, 32'(mem_done_o));
            check_value("busy_o", 32'd0, 32'(busy_o));
        end
    endtask

    task automatic report_and_finish();
        $display("checks: %0d  mismatches: %0d  timeouts: %0d  assertion failures: %0d",
                 checks, errors, timeouts, assert_errors);
        if (errors == 0 && timeouts == 0 && assert_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        rst           = 1'b1;
        exu_done_i    = 1'b0;
        pc_i          = '0;
        inst_i        = '0;
        result_i      = '0;
        addr_i        = '0;
        rs2_data_i    = '0;
        rd_addr_i     = '0;
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        assert_errors = 0;
        timed_out     = 1'b0;
        void'($urandom(32'haff2_2fde));

        // Opcode zero marks the end of the table
        for (int i = 0; i < FIELDS * MAX_PAT; i++) begin
            pat_mem[i] = '0;
        end
        $readmemh("verification/mem_stage_patterns.txt", pat_mem);
        n_pat = 0;
        while (n_pat < MAX_PAT && pat_mem[n_pat*FIELDS] != 0) begin
            n_pat++;
        end
        if (n_pat == 0) begin
            errors++;
            $display("pattern file is missing or holds no instructions");
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("mem_done_o", 32'd0, 32'(mem_done_o));
        check_value("busy_o", 32'd0, 32'(busy_o));
        check_value("load_data_o", 32'd0, load_data_o);
        check_value("pc_o", 32'd0, pc_o);
        check_value("inst_o", 32'd0, inst_o);
        check_value("result_o", 32'd0, result_o);
        check_value("rd_addr_o", 32'd0, 32'(rd_addr_o));

        for (int i = 0; i < n_pat && !timed_out; i++) begin
            run_instruction(i, timed_out);
            if (!timed_out) begin
                gap = int'($urandom % 4);
                repeat (gap) @(posedge clk);
            end
        end

        report_and_finish();
    end

endmodule

/* verification/mem_stage_assert.sv */
`timescale 1ns/1ns

module mem_stage_assert
    import lsu_bus_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input ctrl_state_t state_i,
    input logic        awvalid_i,
    input logic        awready_i,
    input logic        wvalid_i,
    input logic        arvalid_i,
    input logic        arready_i,
    input logic        bready_i,
    input logic        rready_i,
    input logic        done_i
);

    // Request valids hold until the SRAM accepts them
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        (awvalid_i && !awready_i) |=> (awvalid_i && wvalid_i))
        else begin
            $error("awvalid or wvalid dropped before acceptance");
            mem_stage_tb.assert_errors = mem_stage_tb.assert_errors + 1;
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid_i && !arready_i) |=> arvalid_i)
        else begin
            $error("arvalid dropped before acceptance");
            mem_stage_tb.assert_errors = mem_stage_tb.assert_errors + 1;
        end

    // One direction per instruction
    a_one_dir: assert property (@(posedge clk) disable iff (rst)
        !(awvalid_i && arvalid_i))
        else begin
            $error("awvalid and arvalid high together");
            mem_stage_tb.assert_errors = mem_stage_tb.assert_errors + 1;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done_i |=> !done_i)
        else begin
            $error("done_o high for more than one cycle");
            mem_stage_tb.assert_errors = mem_stage_tb.assert_errors + 1;
        end

    a_ready_wait: assert property (@(posedge clk) disable iff (rst)
        (bready_i || rready_i) |-> (state_i == ST_WAIT))
        else begin
            $error("bready or rready high outside ST_WAIT");
            mem_stage_tb.assert_errors = mem_stage_tb.assert_errors + 1;
        end

endmodule

/* design/mem_stage_top.sv */
`timescale 1ns/1ns
`include "mem_stage_params.svh"

module mem_stage_top
    import rv_isa_pkg::*, lsu_bus_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      exu_done_i,
    input  logic [`MS_XLEN-1:0]       pc_i,
    input  logic [`MS_XLEN-1:0]       inst_i,
    input  logic [`MS_XLEN-1:0]       result_i,
    input  logic [`MS_XLEN-1:0]       addr_i,
    input  logic [`MS_XLEN-1:0]       rs2_data_i,
    input  logic [`MS_REG_ADDR_W-1:0] rd_addr_i,
    output logic                      mem_done_o,
    output logic [`MS_XLEN-1:0]       pc_o,
    output logic [`MS_XLEN-1:0]       inst_o,
    output logic [`MS_XLEN-1:0]       result_o,
    output logic [`MS_REG_ADDR_W-1:0] rd_addr_o,
    output logic [`MS_XLEN-1:0]       load_data_o,
    output logic                      busy_o
);

    // Captured bundle
    logic                      take;
    logic [`MS_XLEN-1:0]       pc_q, inst_q, result_q, addr_q, rs2_q;
    logic [`MS_REG_ADDR_W-1:0] rd_q;
    logic [2:0]                funct3;
    access_kind_t              kind;

    // Bus between controller and SRAM
    logic                      awvalid, awready, wvalid, bvalid, bready;
    logic                      arvalid, arready, rvalid, rready;
    logic [`MS_XLEN-1:0]       awaddr, wdata, araddr, rdata;
    logic [`MS_XLEN/8-1:0]     wstrb;
    bus_resp_t                 bresp, rresp;
    logic                      rsp_take;

    mem_stage_latch u_latch (
        .clk(clk), .rst(rst), .exu_done_i(exu_done_i), .busy_i(busy_o),
        .pc_i(pc_i), .inst_i(inst_i), .result_i(result_i), .addr_i(addr_i),
        .rs2_data_i(rs2_data_i), .rd_addr_i(rd_addr_i), .take_o(take),
        .pc_q_o(pc_q), .inst_q_o(inst_q), .result_q_o(result_q), .addr_q_o(addr_q),
        .rs2_q_o(rs2_q), .rd_q_o(rd_q), .funct3_o(funct3), .kind_o(kind)
    );

    mem_access_ctrl u_ctrl (
        .clk(clk), .rst(rst), .take_i(take), .kind_i(kind), .funct3_i(funct3),
        .addr_i(addr_q), .rs2_i(rs2_q), .awready_i(awready), .arready_i(arready),
        .bvalid_i(bvalid), .rvalid_i(rvalid), .bresp_i(bresp), .rresp_i(rresp),
        .awvalid_o(awvalid), .awaddr_o(awaddr), .wvalid_o(wvalid), .wdata_o(wdata),
        .wstrb_o(wstrb), .bready_o(bready), .arvalid_o(arvalid), .araddr_o(araddr),
        .rready_o(rready), .rsp_take_o(rsp_take), .done_o(mem_done_o), .busy_o(busy_o)
    );

    sram_axi_lite u_sram (
        .clk(clk), .rst(rst), .awvalid_i(awvalid), .awaddr_i(awaddr),
        .wvalid_i(wvalid), .wdata_i(wdata), .wstrb_i(wstrb), .bready_i(bready),
        .arvalid_i(arvalid), .araddr_i(araddr), .rready_i(rready),
        .awready_o(awready), .bvalid_o(bvalid), .bresp_o(bresp), .arready_o(arready),
        .rvalid_o(rvalid), .rdata_o(rdata), .rresp_o(rresp)
    );

    load_align u_align (
        .clk(clk), .rst(rst), .rsp_take_i(rsp_take), .rdata_i(rdata), .addr_i(addr_q),
        .funct3_i(funct3), .kind_i(kind), .done_i(mem_done_o), .pc_i(pc_q),
        .inst_i(inst_q), .result_i(result_q), .rd_i(rd_q), .load_data_o(load_data_o),
        .pc_o(pc_o), .inst_o(inst_o), .result_o(result_o), .rd_addr_o(rd_addr_o)
    );

endmodule

/* design/load_align.sv */
`timescale 1ns/1ns
`include "mem_stage_params.svh"

module load_align
    import rv_isa_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rsp_take_i,
    input  logic [`MS_XLEN-1:0]       rdata_i,
    input  logic [`MS_XLEN-1:0]       addr_i,
    input  logic [2:0]                funct3_i,
    input  access_kind_t              kind_i,
    input  logic                      done_i,
    input  logic [`MS_XLEN-1:0]       pc_i,
    input  logic [`MS_XLEN-1:0]       inst_i,
    input  logic [`MS_XLEN-1:0]       result_i,
    input  logic [`MS_REG_ADDR_W-1:0] rd_i,
    output logic [`MS_XLEN-1:0]       load_data_o,
    output logic [`MS_XLEN-1:0]       pc_o,
    output logic [`MS_XLEN-1:0]       inst_o,
    output logic [`MS_XLEN-1:0]       result_o,
    output logic [`MS_REG_ADDR_W-1:0] rd_addr_o
);

    logic [`MS_XLEN-1:0]       shifted;
    logic [`MS_XLEN-1:0]       extended;
    logic [`MS_XLEN-1:0]       load_q;
    logic [`MS_XLEN-1:0]       load_live;
    logic [`MS_XLEN-1:0]       load_hold;
    logic [`MS_XLEN-1:0]       pc_hold;
    logic [`MS_XLEN-1:0]       inst_hold;
    logic [`MS_XLEN-1:0]       result_hold;
    logic [`MS_REG_ADDR_W-1:0] rd_hold;

    // Bring the addressed byte or half down to bit 0
    assign shifted = rdata_i >> {addr_i[1:0], 3'b000};

    always_comb begin
        case (funct3_i)
            F3_B:    extended = {{24{shifted[7]}}, shifted[7:0]};
            F3_BU:   extended = {24'b0, shifted[7:0]};
            F3_H:    extended = {{16{shifted[15]}}, shifted[15:0]};
            F3_HU:   extended = {16'b0, shifted[15:0]};
            default: extended = rdata_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rsp_take_i) begin
            load_q <= extended;
        end
    end

    assign load_live = (kind_i == ACC_LOAD) ? load_q : '0;

    // Keep the last completed instruction visible until the next done
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_hold   <= '0;
            pc_hold     <= '0;
            inst_hold   <= '0;
            result_hold <= '0;
            rd_hold     <= '0;
        end else if (done_i) begin
            load_hold   <= load_live;
            pc_hold     <= pc_i;
            inst_hold   <= inst_i;
            result_hold <= result_i;
            rd_hold     <= rd_i;
        end
    end

    // During done the captured bundle is already final
    assign load_data_o = done_i ? load_live : load_hold;
    assign pc_o        = done_i ? pc_i : pc_hold;
    assign inst_o      = done_i ? inst_i : inst_hold;
    assign result_o    = done_i ? result_i : result_hold;
    assign rd_addr_o   = done_i ? rd_i : rd_hold;

endmodule

/* design/sram_axi_lite.sv */
`timescale 1ns/1ns
`include "mem_stage_params.svh"

module sram_axi_lite
    import lsu_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   awvalid_i,
    input  logic [`MS_XLEN-1:0]    awaddr_i,
    input  logic                   wvalid_i,
    input  logic [`MS_XLEN-1:0]    wdata_i,
    input  logic [`MS_XLEN/8-1:0]  wstrb_i,
    input  logic                   bready_i,
    input  logic                   arvalid_i,
    input  logic [`MS_XLEN-1:0]    araddr_i,
    input  logic                   rready_i,
    output logic                   awready_o,
    output logic                   bvalid_o,
    output bus_resp_t              bresp_o,
    output logic                   arready_o,
    output logic                   rvalid_o,
    output logic [`MS_XLEN-1:0]    rdata_o,
    output bus_resp_t              rresp_o
);

    localparam int LANES = `MS_XLEN / 8;
    localparam int OFF_W = $clog2(LANES);
    localparam int IDX_W = $clog2(`MS_SRAM_DEPTH);
    localparam int CNT_W = $clog2(`MS_SRAM_LATENCY + 1);

    logic [`MS_XLEN-1:0] mem [`MS_SRAM_DEPTH];
    logic [`MS_XLEN-1:0] rdata_q;
    logic [CNT_W-1:0]    cnt;
    logic                pending;
    logic                is_wr;
    logic                rsp_valid;
    logic                wr_go;
    logic                rd_go;

    // One transaction at a time, write wins if both arrive
    assign awready_o = !pending;
    assign arready_o = !pending;
    assign wr_go     = awvalid_i && wvalid_i && !pending;
    assign rd_go     = arvalid_i && !pending && !wr_go;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MS_SRAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_go) begin
            for (int b = 0; b < LANES; b++) begin
                if (wstrb_i[b]) begin
                    mem[awaddr_i[OFF_W +: IDX_W]][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            rdata_q <= mem[araddr_i[OFF_W +: IDX_W]];
        end
    end

    // Latency counter, then hold the response until ready
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending   <= 1'b0;
            is_wr     <= 1'b0;
            rsp_valid <= 1'b0;
            cnt       <= '0;
        end else if (wr_go || rd_go) begin
            pending <= 1'b1;
            is_wr   <= wr_go;
            cnt     <= '0;
        end else if (pending && !rsp_valid) begin
            if (cnt == CNT_W'(`MS_SRAM_LATENCY - 1)) begin
                rsp_valid <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (rsp_valid && (is_wr ? bready_i : rready_i)) begin
            pending   <= 1'b0;
            rsp_valid <= 1'b0;
        end
    end

    assign bvalid_o = rsp_valid && is_wr;
    assign rvalid_o = rsp_valid && !is_wr;
    assign rdata_o  = rdata_q;
    assign bresp_o  = RESP_OKAY;
    assign rresp_o  = RESP_OKAY;

endmodule

/* design/mem_access_ctrl.sv */
`timescale 1ns/1ns
`include "mem_stage_params.svh"

module mem_access_ctrl
    import rv_isa_pkg::*, lsu_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   take_i,
    input  access_kind_t           kind_i,
    input  logic [2:0]             funct3_i,
    input  logic [`MS_XLEN-1:0]    addr_i,
    input  logic [`MS_XLEN-1:0]    rs2_i,
    input  logic                   awready_i,
    input  logic                   arready_i,
    input  logic                   bvalid_i,
    input  logic                   rvalid_i,
    input  bus_resp_t              bresp_i,
    input  bus_resp_t              rresp_i,
    output logic                   awvalid_o,
    output logic [`MS_XLEN-1:0]    awaddr_o,
    output logic                   wvalid_o,
    output logic [`MS_XLEN-1:0]    wdata_o,
    output logic [`MS_XLEN/8-1:0]  wstrb_o,
    output logic                   bready_o,
    output logic                   arvalid_o,
    output logic [`MS_XLEN-1:0]    araddr_o,
    output logic                   rready_o,
    output logic                   rsp_take_o,
    output logic                   done_o,
    output logic                   busy_o
);

    ctrl_state_t state;
    logic        is_load;
    logic        is_store;
    logic        req_accepted;
    logic        rsp_seen;
    logic        resp_ok;
    logic [1:0]  off;

    assign is_load      = (kind_i == ACC_LOAD);
    assign is_store     = (kind_i == ACC_STORE);
    assign req_accepted = is_store ? awready_i : arready_i;
    assign rsp_seen     = is_store ? bvalid_i : rvalid_i;
    assign resp_ok      = is_store ? (bresp_i == RESP_OKAY) : (rresp_i == RESP_OKAY);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (take_i) state <= ST_REQ;
                ST_REQ: begin
                    // Non-memory instructions skip the bus entirely
                    if (kind_i == ACC_NONE) begin
                        state <= ST_DONE;
                    end else if (req_accepted) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: if (rsp_seen) state <= ST_DONE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request valids held through ST_REQ until accepted
    assign awvalid_o = (state == ST_REQ) && is_store;
    assign wvalid_o  = (state == ST_REQ) && is_store;
    assign arvalid_o = (state == ST_REQ) && is_load;
    assign awaddr_o  = {addr_i[`MS_XLEN-1:2], 2'b00};
    assign araddr_o  = {addr_i[`MS_XLEN-1:2], 2'b00};

    assign bready_o   = (state == ST_WAIT);
    assign rready_o   = (state == ST_WAIT);
    assign rsp_take_o = (state == ST_WAIT) && rvalid_i && is_load && resp_ok;
    assign done_o     = (state == ST_DONE);
    assign busy_o     = (state != ST_IDLE);

    // Store lane placement by byte offset
    assign off = addr_i[1:0];

    always_comb begin
        case (funct3_i)
            F3_B: begin
                wdata_o = {4{rs2_i[7:0]}};
                wstrb_o = 4'b0001 << off;
            end
            F3_H: begin
                wdata_o = {2{rs2_i[15:0]}};
                wstrb_o = 4'b0011 << {off[1], 1'b0};
            end
            default: begin
                wdata_o = rs2_i;
                wstrb_o = 4'b1111;
            end
        endcase
    end

endmodule

/* design/mem_stage_latch.sv */
`timescale 1ns/1ns
`include "mem_stage_params.svh"

module mem_stage_latch
    import rv_isa_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      exu_done_i,
    input  logic                      busy_i,
    input  logic [`MS_XLEN-1:0]       pc_i,
    input  logic [`MS_XLEN-1:0]       inst_i,
    input  logic [`MS_XLEN-1:0]       result_i,
    input  logic [`MS_XLEN-1:0]       addr_i,
    input  logic [`MS_XLEN-1:0]       rs2_data_i,
    input  logic [`MS_REG_ADDR_W-1:0] rd_addr_i,
    output logic                      take_o,
    output logic [`MS_XLEN-1:0]       pc_q_o,
    output logic [`MS_XLEN-1:0]       inst_q_o,
    output logic [`MS_XLEN-1:0]       result_q_o,
    output logic [`MS_XLEN-1:0]       addr_q_o,
    output logic [`MS_XLEN-1:0]       rs2_q_o,
    output logic [`MS_REG_ADDR_W-1:0] rd_q_o,
    output logic [2:0]                funct3_o,
    output access_kind_t              kind_o
);

    logic [6:0] opcode;

    // Strobes arriving while the stage is occupied are dropped
    assign take_o = exu_done_i && !busy_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q_o     <= '0;
            inst_q_o   <= '0;
            result_q_o <= '0;
            addr_q_o   <= '0;
            rs2_q_o    <= '0;
            rd_q_o     <= '0;
        end else if (take_o) begin
            pc_q_o     <= pc_i;
            inst_q_o   <= inst_i;
            result_q_o <= result_i;
            addr_q_o   <= addr_i;
            rs2_q_o    <= rs2_data_i;
            rd_q_o     <= rd_addr_i;
        end
    end

    // Decode from the held instruction
    assign opcode   = inst_q_o[6:0];
    assign funct3_o = inst_q_o[14:12];

    always_comb begin
        case (opcode)
            OPC_LOAD:  kind_o = ACC_LOAD;
            OPC_STORE: kind_o = ACC_STORE;
            default:   kind_o = ACC_NONE;
        endcase
    end

endmodule

/* design/lsu_bus_pkg.sv */
package lsu_bus_pkg;

    // Access controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_DONE
    } ctrl_state_t;

    // Response codes on the B and R channels
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } bus_resp_t;

endpackage

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes of the memory instructions
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // Access width and sign selection in funct3
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // What the stage has to do with the captured instruction
    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_LOAD,
        ACC_STORE
    } access_kind_t;

endpackage

/* design/mem_stage_params.svh */
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// Data and address width
`define MS_XLEN         32
`define MS_REG_ADDR_W   5

// Data SRAM geometry and response delay (latency must be at least 1)
`define MS_SRAM_DEPTH   256
`define MS_SRAM_LATENCY 2

`endif
